// ==== hdl/fetch_pkg.sv ====
// Shared geometry, structs and enums for the fetch subsystem; import with fetch_pkg::*
package fetch_pkg;

    //////////////////////////////
    // Cache geometry and address split
    //////////////////////////////
    localparam int LINE_COUNT = 512;
    localparam int INDEX_LSB  = 2;          // Line index is addr[10:2]
    localparam int INDEX_MSB  = 10;
    localparam int TAG_LSB    = 11;         // Tag is addr[18:11]
    localparam int TAG_MSB    = 18;

    localparam int TAG_W      = 8;
    localparam int INDEX_W    = 9;
    localparam int WORD_W     = 32;

    //////////////////////////////
    // RV32I major opcodes, instr[6:0]
    //////////////////////////////
    localparam logic [6:0] RV_LUI    = 7'b0110111;
    localparam logic [6:0] RV_AUIPC  = 7'b0010111;
    localparam logic [6:0] RV_JAL    = 7'b1101111;
    localparam logic [6:0] RV_JALR   = 7'b1100111;
    localparam logic [6:0] RV_BRANCH = 7'b1100011;
    localparam logic [6:0] RV_LOAD   = 7'b0000011;
    localparam logic [6:0] RV_STORE  = 7'b0100011;
    localparam logic [6:0] RV_OP_IMM = 7'b0010011;
    localparam logic [6:0] RV_OP     = 7'b0110011;
    localparam logic [6:0] RV_SYSTEM = 7'b1110011;

    //////////////////////////////
    // Types
    //////////////////////////////
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] word;
    } line_t;                               // 41 bits per line

    typedef struct packed {
        logic [31:0]       pc;
        logic [WORD_W-1:0] instr;
    } fetch_t;

    typedef enum logic [3:0] {
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
        OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM, OPC_ILLEGAL
    } opcode_e;

    typedef struct packed {
        logic [31:0]       pc;
        logic [WORD_W-1:0] instr;
        opcode_e           opc;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
    } decoded_t;

    typedef enum logic [1:0] {
        ST_CLEAR,                           // Invalidate one line per cycle
        ST_SETTLE,
        ST_SERVE
    } cache_state_e;

endpackage

// ==== hdl/icache_line_ram.sv ====
// Line storage of the instruction cache, written on the clock edge and read combinationally
`timescale 1ns/1ps

module icache_line_ram import fetch_pkg::*; (
    input  logic               clk_i,

    input  logic               wen_i,
    input  logic [INDEX_W-1:0] waddr_i,
    input  line_t              wline_i,

    input  logic [INDEX_W-1:0] raddr_i,
    output line_t              rline_o
);

    //////////////////////////////
    // Storage array
    //////////////////////////////
    line_t mem [LINE_COUNT];

    // Written by the clear pass and by line fills
    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            mem[waddr_i] <= wline_i;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////
    // Asynchronous read for a same-cycle hit decision
    assign rline_o = mem[raddr_i];

endmodule

// ==== hdl/icache_ctrl.sv ====
// Direct-mapped instruction cache controller with clear pass, hit check and miss fill
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic [31:0]       fetch_pc_i,
    output logic              hit_o,
    output fetch_t            fetch_o,

    output logic              mem_req_o,
    input  logic              mem_ready_i,
    input  logic [WORD_W-1:0] mem_rdata_i
);

    cache_state_e       state;
    cache_state_e       state_nxt;
    logic [INDEX_W-1:0] clr_cnt;

    logic [INDEX_W-1:0] fetch_index;
    logic [TAG_W-1:0]   fetch_tag;
    line_t              rline;
    line_t              wline;
    logic               wen;
    logic [INDEX_W-1:0] waddr;
    logic               tag_match;

    assign fetch_index = fetch_pc_i[INDEX_MSB:INDEX_LSB];
    assign fetch_tag   = fetch_pc_i[TAG_MSB:TAG_LSB];

    //////////////////////////////
    // State machine
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_CLEAR;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_CLEAR:  if (clr_cnt == INDEX_W'(LINE_COUNT - 1)) state_nxt = ST_SETTLE;
            ST_SETTLE: state_nxt = ST_SERVE;
            ST_SERVE:  state_nxt = ST_SERVE;    // No flush after the clear pass
            default:   state_nxt = ST_CLEAR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clr_cnt <= '0;
        end else if (state == ST_CLEAR) begin
            clr_cnt <= clr_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Line write mux
    //////////////////////////////
    always_comb begin
        wen   = 1'b0;
        waddr = fetch_index;
        wline = '{valid: 1'b1, tag: fetch_tag, word: mem_rdata_i};
        case (state)
            ST_CLEAR: begin
                wen   = 1'b1;
                waddr = clr_cnt;
                wline = '0;                     // Invalid line
            end
            ST_SERVE:  wen = mem_ready_i && !tag_match;  // Fill on ready pulse
            ST_SETTLE: wen = 1'b0;
            default:   wen = 1'b0;
        endcase
    end

    icache_line_ram i_line_ram (
        .clk_i   (clk_i),
        .wen_i   (wen),
        .waddr_i (waddr),
        .wline_i (wline),
        .raddr_i (fetch_index),
        .rline_o (rline)
    );

    //////////////////////////////
    // Hit and miss
    //////////////////////////////
    assign tag_match = rline.valid && (rline.tag == fetch_tag);
    assign hit_o     = (state == ST_SERVE) && tag_match;
    assign mem_req_o = (state == ST_SERVE) && !tag_match;
    assign fetch_o   = '{pc: fetch_pc_i, instr: rline.word};

    //////////////////////////////
    // Assertions
    //////////////////////////////
    // Only ST_SERVE is entered from outside ST_CLEAR
    a_hit_only_serving: assert property (@(posedge clk_i) disable iff (rst_i)
        hit_o |-> $past(state) != ST_CLEAR)
        else $error("icache hit outside ST_SERVE");

    // Every line is known after the clear pass
    a_req_hit_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        state == ST_SERVE |-> $onehot({mem_req_o, hit_o}))
        else $error("icache request and hit not exclusive while serving");

    // A fill must turn into a hit once the address holds still
    a_fill_then_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o && mem_ready_i) ##1 $stable(fetch_pc_i) |-> hit_o)
        else $error("icache fill not followed by a hit");

endmodule

// ==== hdl/pc_unit.sv ====
// Program counter of the fetch path; advances on each delivered word and takes redirects
`timescale 1ns/1ps

module pc_unit (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,

    input  logic        hit_i,
    output logic [31:0] fetch_pc_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_nxt;

    //////////////////////////////
    // Next PC select
    //////////////////////////////
    always_comb begin
        if (redirect_i) begin
            pc_nxt = redirect_pc_i;         // Redirect wins over a hit
        end else if (hit_i) begin
            pc_nxt = pc_q + 32'd4;
        end else begin
            pc_nxt = pc_q;                  // Waiting on a miss
        end
    end

    //////////////////////////////
    // PC register
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign fetch_pc_o = pc_q;

    //////////////////////////////
    // Assertions
    //////////////////////////////
    // Catches a misaligned redirect target
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_pc_o[1:0] == 2'b00)
        else $error("fetch PC not word aligned");

endmodule

// ==== hdl/decode_stage.sv ====
// Decode stage; registers each delivered word and sorts it by major opcode and register fields
`timescale 1ns/1ps

module decode_stage import fetch_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     hit_i,
    input  logic     redirect_i,
    input  fetch_t   fetch_i,

    output logic     dec_valid_o,
    output decoded_t dec_o
);

    logic     take;
    decoded_t dec_nxt;
    decoded_t dec_q;
    logic     dec_valid_q;

    //////////////////////////////
    // Opcode classification
    //////////////////////////////
    function automatic opcode_e classify(input logic [6:0] major);
        case (major)
            RV_LUI:    return OPC_LUI;
            RV_AUIPC:  return OPC_AUIPC;
            RV_JAL:    return OPC_JAL;
            RV_JALR:   return OPC_JALR;
            RV_BRANCH: return OPC_BRANCH;
            RV_LOAD:   return OPC_LOAD;
            RV_STORE:  return OPC_STORE;
            RV_OP_IMM: return OPC_OP_IMM;
            RV_OP:     return OPC_OP;
            RV_SYSTEM: return OPC_SYSTEM;
            default:   return OPC_ILLEGAL;
        endcase
    endfunction

    // A word delivered in a redirect cycle is on the old path
    assign take = hit_i && !redirect_i;

    always_comb begin
        dec_nxt.pc    = fetch_i.pc;
        dec_nxt.instr = fetch_i.instr;
        dec_nxt.opc   = classify(fetch_i.instr[6:0]);
        dec_nxt.rd    = fetch_i.instr[11:7];
        dec_nxt.rs1   = fetch_i.instr[19:15];
        dec_nxt.rs2   = fetch_i.instr[24:20];
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= take;
        end
    end

    // Payload register qualified by dec_valid_q
    always_ff @(posedge clk_i) begin
        if (take) begin
            dec_q <= dec_nxt;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

endmodule

// ==== hdl/fetch_subsystem.sv ====
// Top level of the fetch path; PC unit, instruction cache and decode stage with a memory port
`timescale 1ns/1ps

module fetch_subsystem import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              redirect_i,
    input  logic [31:0]       redirect_pc_i,

    // Memory port
    output logic              mem_req_o,
    output logic [31:0]       mem_addr_o,
    input  logic              mem_ready_i,
    input  logic [WORD_W-1:0] mem_rdata_i,

    output logic              dec_valid_o,
    output decoded_t          dec_o
);

    logic [31:0] fetch_pc;
    logic        hit;
    fetch_t      fetch;

    //////////////////////////////
    // Producer
    //////////////////////////////
    pc_unit i_pc_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .hit_i         (hit),
        .fetch_pc_o    (fetch_pc)
    );

    //////////////////////////////
    // Cache
    //////////////////////////////
    icache_ctrl i_icache_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .fetch_pc_i  (fetch_pc),
        .hit_o       (hit),
        .fetch_o     (fetch),
        .mem_req_o   (mem_req_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i)
    );

    assign mem_addr_o = fetch_pc;           // Memory always sees the fetch address

    //////////////////////////////
    // Consumer
    //////////////////////////////
    decode_stage i_decode_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hit_i       (hit),
        .redirect_i  (redirect_i),
        .fetch_i     (fetch),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o)
    );

endmodule

// ==== verification/tb_mem_model.sv ====
// Testbench memory behind the cache port; random ready delay of 1 to 4 cycles, counts requests
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  logic [31:0] addr_i,
    output logic        ready_o,
    output logic [31:0] rdata_o,
    output logic        busy_o,
    output int          req_count_o
);

    logic [31:0] mem [0:(1 << 17) - 1];     // Indexed by addr[18:2]
    logic        req_q;
    int          delay;

    initial begin
        void'($urandom(42));
        for (int i = 0; i < (1 << 17); i++) begin
            mem[i] = $urandom();
        end
        ready_o     = 1'b0;
        rdata_o     = '0;
        busy_o      = 1'b0;
        delay       = 0;
        req_q       = 1'b0;
        req_count_o = 0;
    end

    //////////////////////////////
    // Ready pulse after a random delay
    //////////////////////////////
    always @(posedge clk_i) begin
        ready_o <= 1'b0;
        if (rst_i) begin
            busy_o <= 1'b0;
        end else if (busy_o) begin
            if (delay <= 1) begin
                ready_o <= 1'b1;
                rdata_o <= mem[addr_i[18:2]];   // Word at the address seen now
                busy_o  <= 1'b0;
            end else begin
                delay <= delay - 1;
            end
        end else if (req_i && !ready_o) begin   // Skip the stale request of a fill edge
            busy_o <= 1'b1;
            delay  <= $urandom_range(4, 1);
        end
    end

    // Request counter on rising edges of the request level
    always @(posedge clk_i) begin
        req_q <= req_i;
        if (!rst_i && req_i && !req_q) begin
            req_count_o <= req_count_o + 1;
        end
    end

endmodule

// ==== verification/tb_fetch_subsystem.sv ====
// Testbench of the fetch subsystem; runs the stimulus table against a memory model
`timescale 1ns/1ps

module tb_fetch_subsystem import fetch_pkg::*; ();

    localparam logic [31:0] PARK_PC = 32'h0000_07FC;   // Index 511 lies outside every row
    localparam int          TIMEOUT = 200;

    typedef struct {
        string       name;
        logic [31:0] start;
        int          count;
        int          misses;
        int          redir_idx;                        // -1 when the row has no redirect
        logic [31:0] redir_pc;
    } row_t;

    logic clk_i, rst_i, redirect_i, mem_req_o, mem_ready_i, dec_valid_o, mem_busy;
    logic [31:0] redirect_pc_i, mem_addr_o, mem_rdata_i;
    decoded_t dec_o;
    int req_count;
    logic hold_redirect, pulse_redirect;
    logic [31:0] target_pc;
    row_t rows [6];

    fetch_subsystem i_fetch_subsystem (
        .clk_i, .rst_i, .redirect_i, .redirect_pc_i, .mem_req_o, .mem_addr_o,
        .mem_ready_i, .mem_rdata_i, .dec_valid_o, .dec_o
    );

    tb_mem_model i_mem (
        .clk_i, .rst_i, .req_i (mem_req_o), .addr_i (mem_addr_o), .ready_o (mem_ready_i),
        .rdata_o (mem_rdata_i), .busy_o (mem_busy), .req_count_o (req_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Redirect driver that holds for parking or pulses for one cycle
    always @(posedge clk_i) begin
        redirect_i     <= hold_redirect || pulse_redirect;
        redirect_pc_i  <= target_pc;
        pulse_redirect = 1'b0;
    end

    //////////////////////////////
    // Reference model and checks
    //////////////////////////////
    function automatic opcode_e ref_class(input logic [6:0] op);
        case (op)
            7'h37:   return OPC_LUI;
            7'h17:   return OPC_AUIPC;
            7'h6F:   return OPC_JAL;
            7'h67:   return OPC_JALR;
            7'h63:   return OPC_BRANCH;
            7'h03:   return OPC_LOAD;
            7'h23:   return OPC_STORE;
            7'h13:   return OPC_OP_IMM;
            7'h33:   return OPC_OP;
            7'h73:   return OPC_SYSTEM;
            default: return OPC_ILLEGAL;
        endcase
    endfunction

    function automatic decoded_t ref_decode(input logic [31:0] pc);
        logic [31:0] w;
        decoded_t    d;
        w       = i_mem.mem[pc[18:2]];
        d.pc    = pc;
        d.instr = w;
        d.opc   = ref_class(w[6:0]);
        d.rd    = w[11:7];
        d.rs1   = w[19:15];
        d.rs2   = w[24:20];
        return d;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_decoded(input string name, input decoded_t exp, input decoded_t act);
        if (exp !== act) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input cache_state_e exp,
                               input cache_state_e act);
        if (exp !== act) begin
            stop_run($sformatf("[FAIL] %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    //////////////////////////////
    // Waits with their own timeouts
    //////////////////////////////
    task automatic wait_parked();
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) stop_run("Timeout while parking the fetch address");
        end while (mem_addr_o != PARK_PC || mem_req_o || mem_busy || mem_ready_i);
    endtask

    task automatic wait_result(output int waited);
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) stop_run("Timeout waiting for a decoded word");
        end while (!dec_valid_o);
        waited = n;
    endtask

    task automatic check_clearing();
        int n;
        for (int c = 0; c < 513; c++) begin
            @(negedge clk_i);
            if (dec_valid_o || mem_req_o) stop_run("Output active while the cache clears");
        end
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) stop_run("Timeout waiting for the first memory request");
        end while (!mem_req_o);
        check_count("clearing first request address", 0, mem_addr_o);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] exp_pc;
        int          base;
        int          waited;
        int          span;
        target_pc     = PARK_PC;
        hold_redirect = 1'b1;
        wait_parked();
        hold_redirect  = 1'b0;
        target_pc      = r.start;
        pulse_redirect = 1'b1;
        base           = req_count;
        exp_pc         = r.start;
        span           = 0;
        for (int j = 0; j < r.count; j++) begin
            wait_result(waited);
            if (j > 0) span += waited;
            check_decoded($sformatf("%s word %0d", r.name, j), ref_decode(exp_pc), dec_o);
            if (j == r.redir_idx) begin
                target_pc      = r.redir_pc;
                pulse_redirect = 1'b1;
            end
            // One old-path word is already registered when the redirect lands
            exp_pc = (r.redir_idx >= 0 && j == r.redir_idx + 1) ? r.redir_pc : exp_pc + 4;
        end
        check_count({r.name, " misses"}, r.misses, req_count - base);
        if (r.misses == 0) begin
            // One word per cycle on hits plus one dropped word per redirect
            check_count({r.name, " cycles"}, r.count - 1 + (r.redir_idx >= 0 ? 1 : 0), span);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rst_i          = 1'b1;
        redirect_i     = 1'b0;
        redirect_pc_i  = '0;
        hold_redirect  = 1'b0;
        pulse_redirect = 1'b0;
        target_pc      = '0;

        rows[0] = '{"cold sequential", 32'h0000_0000, 16, 16, -1, 32'h0};
        rows[1] = '{"warm refetch", 32'h0000_0000, 16, 0, -1, 32'h0};
        rows[2] = '{"tag conflict", 32'h0000_0800, 16, 16, -1, 32'h0};
        rows[3] = '{"conflict refetch", 32'h0000_0000, 16, 16, -1, 32'h0};
        rows[4] = '{"opcode classes", 32'h0000_0400, 11, 11, -1, 32'h0};
        rows[5] = '{"redirect cancel", 32'h0000_0000, 8, 0, 3, 32'h0000_0030};

        repeat (7) @(posedge clk_i);
        @(negedge clk_i);
        check_state("reset state", ST_CLEAR, i_fetch_subsystem.i_icache_ctrl.state);
        @(posedge clk_i);
        rst_i <= 1'b0;

        // Opcode row words with one per class and an illegal one last
        i_mem.mem[256] = {7'h00, 5'd1, 5'd2, 3'b000, 5'd3, 7'h37};
        i_mem.mem[257] = {7'h00, 5'd4, 5'd5, 3'b000, 5'd6, 7'h17};
        i_mem.mem[258] = {7'h00, 5'd7, 5'd8, 3'b000, 5'd9, 7'h6F};
        i_mem.mem[259] = {7'h00, 5'd10, 5'd11, 3'b000, 5'd12, 7'h67};
        i_mem.mem[260] = {7'h00, 5'd13, 5'd14, 3'b001, 5'd15, 7'h63};
        i_mem.mem[261] = {7'h00, 5'd16, 5'd17, 3'b010, 5'd18, 7'h03};
        i_mem.mem[262] = {7'h00, 5'd19, 5'd20, 3'b010, 5'd21, 7'h23};
        i_mem.mem[263] = {7'h00, 5'd22, 5'd23, 3'b000, 5'd24, 7'h13};
        i_mem.mem[264] = {7'h20, 5'd25, 5'd26, 3'b000, 5'd27, 7'h33};
        i_mem.mem[265] = {7'h00, 5'd28, 5'd29, 3'b000, 5'd30, 7'h73};
        i_mem.mem[266] = {7'h7F, 5'd31, 5'd0, 3'b111, 5'd31, 7'h7F};

        check_clearing();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/icache_line_ram.sv
hdl/icache_ctrl.sv
hdl/pc_unit.sv
hdl/decode_stage.sv
hdl/fetch_subsystem.sv
verification/tb_mem_model.sv
verification/tb_fetch_subsystem.sv
